//--- Makefile
# Verilator build and run for the TCB subsystem

TOP := tcb_subsystem_tb

.PHONY: all sim lint clean

all: sim

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -f build.f --top-module tcb_subsystem

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+.
tcb_pkg.sv
tcb_passthrough.sv
tcb_decoder.sv
tcb_memory.sv
tcb_gpio.sv
tcb_subsystem.sv
tcb_subsystem_tb.sv

//--- tcb_decoder.sv
// TCB address decoder and response multiplexer
// error responder for unmapped selects

`default_nettype none

`include "tcb_defines.svh"

module tcb_decoder (
  // system
  input  logic              clk,
  input  logic              rst_n,
  // upstream port
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp,
  // memory subordinate
  output tcb_pkg::tcb_req_t mem_req,
  input  tcb_pkg::tcb_rsp_t mem_rsp,
  // gpio subordinate
  output tcb_pkg::tcb_req_t gpio_req,
  input  tcb_pkg::tcb_rsp_t gpio_rsp
);

  import tcb_pkg::*;

  // request side decode
  logic                  sel_mem;
  logic                  sel_gpio;
  logic                  sel_none;
  logic                  trn;
  // error responder ready, high after reset
  logic                  err_rdy;
  // response cycle routing
  logic [`TCB_SEL_W-1:0] sel_q;
  logic                  vld_q;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  assign sel_mem  = (req.adr.fld.sel == `TCB_SEL_MEM);
  assign sel_gpio = (req.adr.fld.sel == `TCB_SEL_GPIO);
  assign sel_none = !(sel_mem || sel_gpio);

  // payload to both, vld only to the selected one
  always_comb begin
    mem_req      = req;
    mem_req.vld  = req.vld & sel_mem;
    gpio_req     = req;
    gpio_req.vld = req.vld & sel_gpio;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_rdy <= 1'b0;
    end else begin
      err_rdy <= 1'b1;
    end
  end

  assign trn = tcb_trn(req, rsp);

  ////////////////////////////////////////
  // response routing
  ////////////////////////////////////////

  // flag which cycle carries a response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= trn;
    end
  end

  // remember where the transfer went
  always_ff @(posedge clk) begin
    if (trn) begin
      sel_q <= req.adr.fld.sel;
    end
  end

  always_comb begin
    // ready follows the current select
    if (sel_mem) rsp.rdy = mem_rsp.rdy;
    else if (sel_gpio) rsp.rdy = gpio_rsp.rdy;
    else rsp.rdy = err_rdy;
    // data and error follow the registered select
    if (sel_q == `TCB_SEL_MEM) begin
      rsp.rdt = mem_rsp.rdt;
      rsp.err = mem_rsp.err;
    end else if (sel_q == `TCB_SEL_GPIO) begin
      rsp.rdt = gpio_rsp.rdt;
      rsp.err = gpio_rsp.err;
    end else begin
      // unmapped, error only in a response cycle
      rsp.rdt = '0;
      rsp.err = vld_q;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // one target per request, subordinates or error responder
  one_target_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({mem_req.vld, gpio_req.vld, req.vld & sel_none})
  );

endmodule

`default_nettype wire

//--- tcb_defines.svh
// bus widths and response delay of the TCB subsystem
// memory depth and address map macros

`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

////////////////////////////////////////
// bus geometry
////////////////////////////////////////

// address, data and byte-enable widths
`define TCB_ABW 16
`define TCB_DBW 32
`define TCB_BEW (`TCB_DBW/8)
// response delay in cycles, fixed
`define TCB_DLY 1

////////////////////////////////////////
// address map
////////////////////////////////////////

// select field in top address bits
`define TCB_SEL_W 4
`define TCB_SEL_MEM 4'd0
`define TCB_SEL_GPIO 4'd1
// memory word address, taken from offset bits 9..2
`define TCB_MEM_AW 8
// gpio width and register offsets
`define TCB_GPIO_W 16
`define TCB_GPIO_OUT 12'h000
`define TCB_GPIO_IN 12'h004

`endif

//--- tcb_gpio.sv
// TCB GPIO subordinate
// output register at offset 0, synchronised input at offset 4

`default_nettype none

`include "tcb_defines.svh"

module tcb_gpio (
  // system
  input  logic                   clk,
  input  logic                   rst_n,
  // TCB port
  input  tcb_pkg::tcb_req_t      req,
  output tcb_pkg::tcb_rsp_t      rsp,
  // pins
  input  logic [`TCB_GPIO_W-1:0] gpio_in,
  output logic [`TCB_GPIO_W-1:0] gpio_out
);

  import tcb_pkg::*;

  logic                   trn;
  logic                   rdy_q;
  logic                   err_q;
  logic [`TCB_DBW-1:0]    rdt_q;
  // output register
  logic [`TCB_GPIO_W-1:0] out_q;
  // two flop input synchroniser
  logic [`TCB_GPIO_W-1:0] in_s1;
  logic [`TCB_GPIO_W-1:0] in_s2;

  assign trn = tcb_trn(req, rsp);

  always_ff @(posedge clk) begin
    in_s1 <= gpio_in;
    in_s2 <= in_s1;
  end

  ////////////////////////////////////////
  // register access
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
      err_q <= 1'b0;
      out_q <= '0;
    end else begin
      rdy_q <= 1'b1;
      // err only for a bad access in the previous cycle
      err_q <= 1'b0;
      if (trn) begin
        if (req.adr.fld.ofs == `TCB_GPIO_OUT) begin
          for (int b = 0; b < `TCB_GPIO_W/8; b++) begin
            if (req.wen && req.ben[b]) out_q[8*b +: 8] <= req.wdt[8*b +: 8];
          end
        end else if ((req.adr.fld.ofs != `TCB_GPIO_IN) || req.wen) begin
          // input register is read only
          err_q <= 1'b1;
        end
      end
    end
  end

  // read data, old value on an output write
  always_ff @(posedge clk) begin
    if (trn) begin
      if (req.adr.fld.ofs == `TCB_GPIO_OUT) begin
        rdt_q <= {{(`TCB_DBW-`TCB_GPIO_W){1'b0}}, out_q};
      end else if ((req.adr.fld.ofs == `TCB_GPIO_IN) && !req.wen) begin
        rdt_q <= {{(`TCB_DBW-`TCB_GPIO_W){1'b0}}, in_s2};
      end else begin
        rdt_q <= '0;
      end
    end
  end

  assign rsp.rdy  = rdy_q;
  assign rsp.rdt  = rdt_q;
  assign rsp.err  = err_q;
  assign gpio_out = out_q;

endmodule

`default_nettype wire

//--- tcb_memory.sv
// TCB memory subordinate, 256 words
// byte enabled writes, registered read data

`default_nettype none

`include "tcb_defines.svh"

module tcb_memory (
  // system
  input  logic              clk,
  input  logic              rst_n,
  // TCB port
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  // word storage
  logic [`TCB_DBW-1:0]    mem [0:2**`TCB_MEM_AW-1];
  // word address from offset bits
  logic [`TCB_MEM_AW-1:0] adr;
  // ready, raised one cycle after reset
  logic                   rdy_q;
  // read data for the response cycle
  logic [`TCB_DBW-1:0]    rdt_q;
  logic                   trn;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  // byte offset bits dropped, word addressed
  assign adr = req.adr.fld.ofs[`TCB_MEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign trn = tcb_trn(req, rsp);

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////

  // read before write, a write returns the old word
  always_ff @(posedge clk) begin
    if (trn) begin
      rdt_q <= mem[adr];
      for (int b = 0; b < `TCB_BEW; b++) begin
        // only enabled byte lanes
        if (req.wen && req.ben[b]) begin
          mem[adr][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  // every address is valid, never an error
  assign rsp.rdy = rdy_q;
  assign rsp.rdt = rdt_q;
  assign rsp.err = 1'b0;

endmodule

`default_nettype wire

//--- tcb_passthrough.sv
// TCB passthrough between a manager port and a subordinate port
// protocol assertions on the handshake and the response

`default_nettype none

`include "tcb_defines.svh"

module tcb_passthrough (
  // system
  input  logic              clk,
  input  logic              rst_n,
  // subordinate port, the manager connects here
  input  tcb_pkg::tcb_req_t sub_req,
  output tcb_pkg::tcb_rsp_t sub_rsp,
  // manager port, the subordinate connects here
  output tcb_pkg::tcb_req_t man_req,
  input  tcb_pkg::tcb_rsp_t man_rsp
);

  import tcb_pkg::*;

  // transfer on this edge
  logic trn;

  ////////////////////////////////////////
  // passthrough
  ////////////////////////////////////////

  // request forward, response back, no added cycles
  assign man_req = sub_req;
  assign sub_rsp = man_rsp;

  assign trn = tcb_trn(sub_req, sub_rsp);

  ////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////

  // manager holds the request while stalled
  req_stable_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (sub_req.vld && !sub_rsp.rdy) |=> $stable(sub_req)
  );

  // an error belongs to a transfer TCB_DLY cycles back
  err_trn_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    sub_rsp.err |-> $past(trn, `TCB_DLY)
  );

  // vld must be known once out of reset
  vld_known_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(sub_req.vld)
  );

endmodule

`default_nettype wire

//--- tcb_pkg.sv
// TCB types: address union, request and response structs
// transfer helper shared by the bus modules

`default_nettype none

`include "tcb_defines.svh"

package tcb_pkg;

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////

  // one address word, flat or split into select and offset
  typedef union packed {
    logic [`TCB_ABW-1:0] flat;
    struct packed {
      logic [`TCB_SEL_W-1:0]          sel;
      logic [`TCB_ABW-`TCB_SEL_W-1:0] ofs;
    } fld;
  } tcb_adr_t;

  ////////////////////////////////////////
  // request and response
  ////////////////////////////////////////

  // manager side
  typedef struct packed {
    logic                vld;
    logic                wen;
    logic [`TCB_BEW-1:0] ben;
    tcb_adr_t            adr;
    logic [`TCB_DBW-1:0] wdt;
  } tcb_req_t;

  // subordinate side, rdt/err valid TCB_DLY cycles after the transfer
  typedef struct packed {
    logic                rdy;
    logic [`TCB_DBW-1:0] rdt;
    logic                err;
  } tcb_rsp_t;

  // transfer happens on an edge with vld and rdy both high
  function automatic logic tcb_trn(tcb_req_t req, tcb_rsp_t rsp);
    return req.vld & rsp.rdy;
  endfunction

endpackage

`default_nettype wire

//--- tcb_subsystem.sv
// TCB subsystem top level
// passthrough, decoder, memory and GPIO

`default_nettype none

`include "tcb_defines.svh"

module tcb_subsystem (
  // system
  input  logic                   clk,
  input  logic                   rst_n,
  // external manager
  input  tcb_pkg::tcb_req_t      req,
  output tcb_pkg::tcb_rsp_t      rsp,
  // gpio pins
  input  logic [`TCB_GPIO_W-1:0] gpio_in,
  output logic [`TCB_GPIO_W-1:0] gpio_out
);

  import tcb_pkg::*;

  // passthrough to decoder
  tcb_req_t dec_req;
  tcb_rsp_t dec_rsp;
  // decoder to subordinates
  tcb_req_t mem_req;
  tcb_rsp_t mem_rsp;
  tcb_req_t gpio_req;
  tcb_rsp_t gpio_rsp;

  ////////////////////////////////////////
  // bus fabric
  ////////////////////////////////////////

  // entry point, checks the external handshake
  tcb_passthrough passthrough_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_req (req),
    .sub_rsp (rsp),
    .man_req (dec_req),
    .man_rsp (dec_rsp)
  );

  tcb_decoder decoder_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (dec_req),
    .rsp      (dec_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp)
  );

  ////////////////////////////////////////
  // subordinates
  ////////////////////////////////////////

  tcb_memory memory_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

  tcb_gpio gpio_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (gpio_req),
    .rsp      (gpio_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

endmodule

`default_nettype wire

//--- tcb_subsystem_tb.sv
// testbench for the TCB subsystem
// reference memory and GPIO model, checking assertions, cycle limit

`default_nettype none

`include "tcb_defines.svh"

module tcb_subsystem_tb;

  import tcb_pkg::*;

  // tests need about 190 cycles, the limit leaves a wide margin
  localparam int max_cycles = 2000;

  // DUT ports
  logic                   clk;
  logic                   rst_n;
  tcb_req_t               req;
  tcb_rsp_t               rsp;
  logic [`TCB_GPIO_W-1:0] gpio_in;
  logic [`TCB_GPIO_W-1:0] gpio_out;

  // run control
  int                     cyc = 0;
  logic                   rst_q;
  integer                 seed;
  logic [31:0]            rnd;
  logic [`TCB_MEM_AW-1:0] wa;
  logic [`TCB_MEM_AW-1:0] wadr [0:63];

  // reference state, byte known flags for never written memory
  logic [`TCB_DBW-1:0]    ref_mem [0:2**`TCB_MEM_AW-1];
  logic [`TCB_BEW-1:0]    ref_kn  [0:2**`TCB_MEM_AW-1];
  logic [`TCB_GPIO_W-1:0] ref_out;
  // model scratch
  logic [`TCB_SEL_W-1:0]  m_sel;
  logic [`TCB_ABW-`TCB_SEL_W-1:0] m_ofs;
  logic [`TCB_MEM_AW-1:0] m_wa;
  logic [`TCB_DBW-1:0]    m_rdt;
  logic [`TCB_DBW-1:0]    m_msk;
  logic                   m_err;
  // expected response in the cycle after a transfer
  logic                   exp_vld;
  logic [`TCB_DBW-1:0]    exp_rdt;
  logic [`TCB_DBW-1:0]    exp_msk;
  logic                   exp_err;

  tcb_subsystem tcb_subsystem_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // expected rdt/err of one transfer, then the state update
  task automatic update_model;
    m_sel = req.adr.fld.sel;
    m_ofs = req.adr.fld.ofs;
    m_rdt = '0;
    m_msk = '1;
    m_err = 1'b0;
    if (m_sel == `TCB_SEL_MEM) begin
      m_wa  = m_ofs[`TCB_MEM_AW+1:2];
      // old word comes back, also on a write
      m_rdt = ref_mem[m_wa];
      for (int b = 0; b < `TCB_BEW; b++) begin
        m_msk[8*b +: 8] = {8{ref_kn[m_wa][b]}};
        if (req.wen && req.ben[b]) begin
          ref_mem[m_wa][8*b +: 8] = req.wdt[8*b +: 8];
          ref_kn[m_wa][b] = 1'b1;
        end
      end
    end else if (m_sel == `TCB_SEL_GPIO) begin
      if (m_ofs == `TCB_GPIO_OUT) begin
        m_rdt[`TCB_GPIO_W-1:0] = ref_out;
        for (int b = 0; b < `TCB_GPIO_W/8; b++) begin
          if (req.wen && req.ben[b]) begin
            ref_out[8*b +: 8] = req.wdt[8*b +: 8];
          end
        end
      end else if ((m_ofs == `TCB_GPIO_IN) && !req.wen) begin
        // pins held stable for several cycles before this read
        m_rdt[`TCB_GPIO_W-1:0] = gpio_in;
      end else begin
        // read only input or undefined offset
        m_err = 1'b1;
      end
    end else begin
      // unmapped select
      m_err = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    rst_q <= rst_n;
    if (!rst_n) begin
      exp_vld <= 1'b0;
      ref_out = '0;
    end else begin
      exp_vld <= req.vld && rsp.rdy;
      if (req.vld && rsp.rdy) begin
        update_model;
        exp_rdt <= m_rdt;
        exp_msk <= m_msk;
        exp_err <= m_err;
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  // quiet bus during reset and the cycle after it
  reset_chk_a: assert property (
    @(posedge clk)
    ((cyc != 0) && (!rst_n || !rst_q)) |-> (!rsp.rdy && !rsp.err && (gpio_out == '0))
  ) else report_mismatch("rdy, err or gpio_out not quiet around reset");

  // response one cycle after each transfer, unknown bytes masked
  rsp_chk_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    exp_vld |-> ((((rsp.rdt ^ exp_rdt) & exp_msk) == '0) && (rsp.err == exp_err))
  ) else report_mismatch($sformatf("rdt %h err %b, model rdt %h err %b",
    $sampled(rsp.rdt), $sampled(rsp.err), $sampled(exp_rdt), $sampled(exp_err)));

  gpio_chk_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    gpio_out == ref_out
  ) else report_mismatch($sformatf("gpio_out %h, model %h",
    $sampled(gpio_out), $sampled(ref_out)));

  // run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("TEST FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  function automatic logic [`TCB_ABW-1:0] mem_word_adr(input logic [`TCB_MEM_AW-1:0] a);
    return {`TCB_SEL_MEM, 2'b00, a, 2'b00};
  endfunction

  function automatic logic [`TCB_ABW-1:0] gpio_reg_adr(input logic [11:0] ofs);
    return {`TCB_SEL_GPIO, ofs};
  endfunction

  // called at edge+2, returns at edge+2 after the transfer edge with vld still high
  task automatic bus_xfer(input logic wen, input logic [`TCB_BEW-1:0] ben,
                          input logic [`TCB_ABW-1:0] adr, input logic [`TCB_DBW-1:0] wdt);
    logic hs;
    req.vld      = 1'b1;
    req.wen      = wen;
    req.ben      = ben;
    req.adr.flat = adr;
    req.wdt      = wdt;
    hs = 1'b0;
    while (!hs) begin
      #1;
      // rdy is settled here and holds to the next edge
      hs = rsp.rdy;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic bus_idle(input int n);
    req.vld = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    seed    = 32'h570d98d1;
    clk     = 1'b0;
    rst_n   = 1'b0;
    req     = '0;
    gpio_in = '0;
    for (int a = 0; a < 2**`TCB_MEM_AW; a++) begin
      ref_kn[a] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    // random words, writes back to back, reads with a gap every 8
    for (int i = 0; i < 64; i++) begin
      rnd     = $random(seed);
      wadr[i] = rnd[`TCB_MEM_AW-1:0];
      bus_xfer(1'b1, 4'hf, mem_word_adr(wadr[i]), $random(seed));
    end
    bus_idle(1);
    for (int i = 0; i < 64; i++) begin
      bus_xfer(1'b0, 4'h0, mem_word_adr(wadr[i]), $random(seed));
      if (i % 8 == 7) begin
        bus_idle(1);
      end
    end
    bus_idle(1);

    // full write, partial write, read back
    for (int k = 0; k < 8; k++) begin
      rnd = $random(seed);
      wa  = rnd[`TCB_MEM_AW-1:0];
      bus_xfer(1'b1, 4'hf, mem_word_adr(wa), $random(seed));
      bus_xfer(1'b1, rnd[11:8], mem_word_adr(wa), $random(seed));
      bus_xfer(1'b0, 4'h0, mem_word_adr(wa), 32'h0);
    end
    bus_idle(1);

    // output register with byte enables, then the input register
    bus_xfer(1'b1, 4'hf, gpio_reg_adr(`TCB_GPIO_OUT), $random(seed));
    bus_xfer(1'b0, 4'h0, gpio_reg_adr(`TCB_GPIO_OUT), 32'h0);
    bus_xfer(1'b1, 4'h1, gpio_reg_adr(`TCB_GPIO_OUT), $random(seed));
    bus_xfer(1'b0, 4'h0, gpio_reg_adr(`TCB_GPIO_OUT), 32'h0);
    bus_idle(1);
    rnd     = $random(seed);
    gpio_in = rnd[`TCB_GPIO_W-1:0];
    bus_idle(3);
    bus_xfer(1'b0, 4'h0, gpio_reg_adr(`TCB_GPIO_IN), 32'h0);
    bus_idle(1);

    // error cases, each followed by a good access
    bus_xfer(1'b0, 4'h0, 16'h2000, 32'h0);
    bus_xfer(1'b0, 4'h0, mem_word_adr(wadr[0]), 32'h0);
    bus_xfer(1'b1, 4'hf, 16'hf004, $random(seed));
    bus_xfer(1'b0, 4'h0, gpio_reg_adr(`TCB_GPIO_OUT), 32'h0);
    bus_xfer(1'b0, 4'h0, gpio_reg_adr(12'h008), 32'h0);
    bus_xfer(1'b0, 4'h0, mem_word_adr(wadr[1]), 32'h0);
    bus_xfer(1'b1, 4'hf, gpio_reg_adr(`TCB_GPIO_IN), $random(seed));
    bus_xfer(1'b0, 4'h0, gpio_reg_adr(`TCB_GPIO_IN), 32'h0);
    bus_idle(2);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
